// File: include/soc_map.svh
`ifndef SOC_MAP_SVH
`define SOC_MAP_SVH

// system bus address map

// on-chip word ram
`define RAM_BASE              64'h0000_0000_8000_0000

// platform interrupt controller window
`define PLIC_BASE             64'h0000_0000_0C00_0000
// 64 MiB, same span as the usual plic layout
`define PLIC_SIZE             64'h0000_0000_0400_0000

// plic register offsets, relative to PLIC_BASE

// one priority word per source id
`define PLIC_PRIORITY_STRIDE  64'h4

// global pending bitmap
`define PLIC_PENDING          64'h1000

// per context enable bitmap
`define PLIC_ENABLE           64'h2000
`define PLIC_ENABLE_STRIDE    64'h80

// per context threshold and claim words
`define PLIC_THRESHOLD        64'h20_0000
`define PLIC_CLAIM            64'h20_0004
`define PLIC_CONTEXT_STRIDE   64'h1000

`endif

// File: logic/soc_bus_pkg.sv
package soc_bus_pkg;

    `include "soc_map.svh"

    // bus and memory widths
    localparam int XLEN = 64;
    localparam int WORD_W = 32;
    // priority and threshold width
    localparam int PRIO_W = 3;
    // machine context 0, supervisor context 1
    localparam int NUM_CTX = 2;

    // address map, taken from the map header
    localparam logic [XLEN-1:0] RAM_BASE_ADDR = `RAM_BASE;
    localparam logic [XLEN-1:0] PLIC_BASE_ADDR = `PLIC_BASE;
    localparam logic [XLEN-1:0] PLIC_SIZE_BYTES = `PLIC_SIZE;
    localparam logic [XLEN-1:0] PRIO_STRIDE = `PLIC_PRIORITY_STRIDE;
    localparam logic [XLEN-1:0] PENDING_OFS = `PLIC_PENDING;
    localparam logic [XLEN-1:0] ENABLE_OFS = `PLIC_ENABLE;
    localparam logic [XLEN-1:0] ENABLE_STRIDE = `PLIC_ENABLE_STRIDE;
    localparam logic [XLEN-1:0] THRESH_OFS = `PLIC_THRESHOLD;
    localparam logic [XLEN-1:0] CLAIM_OFS = `PLIC_CLAIM;
    localparam logic [XLEN-1:0] CTX_STRIDE = `PLIC_CONTEXT_STRIDE;

    // load/store width code, same encoding the cpu puts on the bus
    typedef enum logic [2:0] {
        LS_B  = 3'd0,
        LS_H  = 3'd1,
        LS_W  = 3'd2,
        LS_D  = 3'd3,
        LS_BU = 3'd4,
        LS_HU = 3'd5,
        LS_WU = 3'd6
    } ls_type_t;

    typedef enum logic [1:0] {
        REG_NONE = 2'd0,
        REG_RAM  = 2'd1,
        REG_PLIC = 2'd2
    } region_t;

    // cpu side request
    typedef struct packed {
        logic [XLEN-1:0] address;
        logic [XLEN-1:0] write_data;
        ls_type_t        ls_type;
        logic            read_enable;
        logic            write_enable;
    } bus_req_t;

    // one beat towards a slave, address is relative to the region base
    typedef struct packed {
        logic            read_strobe;
        logic            write_strobe;
        logic            beat;
        logic [XLEN-1:0] address;
        logic [XLEN-1:0] write_data;
        ls_type_t        ls_type;
    } slave_access_t;

    typedef struct packed {
        logic [XLEN-1:0] read_data;
        logic            last;
    } slave_resp_t;

endpackage

// File: logic/bus_responder.sv
`timescale 1ns/1ps

module bus_responder #(
    parameter int RAM_WORDS = 256
) (
    input  logic                          CLOCK_50,
    input  logic                          KEY0,
    input  soc_bus_pkg::bus_req_t         bus_req,
    output soc_bus_pkg::slave_access_t    ram_access,
    output soc_bus_pkg::slave_access_t    plic_access,
    input  soc_bus_pkg::slave_resp_t      ram_resp,
    input  soc_bus_pkg::slave_resp_t      plic_resp,
    output logic [soc_bus_pkg::XLEN-1:0]  bus_read_data,
    output logic                          bus_read_done,
    output logic                          bus_write_done
);
    import soc_bus_pkg::*;

    // first byte past the ram
    localparam logic [XLEN-1:0] RAM_LIMIT = RAM_BASE_ADDR + XLEN'(RAM_WORDS * 4);
    localparam logic [XLEN-1:0] PLIC_LIMIT = PLIC_BASE_ADDR + PLIC_SIZE_BYTES;

    region_t         req_region;
    region_t         region;
    logic            idle;
    logic            start_rd;
    logic            start_wr;
    logic            beat;
    logic [XLEN-1:0] region_base;
    slave_access_t   access;
    slave_resp_t     resp;

    // address decode, only looked at on the start edge
    always_comb begin
        if (bus_req.address >= RAM_BASE_ADDR && bus_req.address < RAM_LIMIT) begin
            req_region = REG_RAM;
        end else if (bus_req.address >= PLIC_BASE_ADDR && bus_req.address < PLIC_LIMIT) begin
            req_region = REG_PLIC;
        end else begin
            req_region = REG_NONE;
        end
    end

    // new request only when nothing is in flight
    assign idle = bus_read_done && bus_write_done;
    assign start_rd = idle && bus_req.read_enable;
    // read wins if both pulses show up together
    assign start_wr = idle && bus_req.write_enable && !bus_req.read_enable;

    always_comb begin
        unique case (region)
            REG_RAM:  region_base = RAM_BASE_ADDR;
            REG_PLIC: region_base = PLIC_BASE_ADDR;
            default:  region_base = '0;
        endcase
    end

    // same beat for both slaves, strobes only on the selected one
    always_comb begin
        access.read_strobe = !bus_read_done;
        access.write_strobe = !bus_write_done;
        access.beat = beat;
        access.address = bus_req.address - region_base;
        access.write_data = bus_req.write_data;
        access.ls_type = bus_req.ls_type;

        ram_access = access;
        plic_access = access;
        if (region != REG_RAM) begin
            ram_access.read_strobe = 1'b0;
            ram_access.write_strobe = 1'b0;
        end
        if (region != REG_PLIC) begin
            plic_access.read_strobe = 1'b0;
            plic_access.write_strobe = 1'b0;
        end
    end

    // unmapped space answers at once with zero
    always_comb begin
        unique case (region)
            REG_RAM:  resp = ram_resp;
            REG_PLIC: resp = plic_resp;
            default: begin
                resp.read_data = '0;
                resp.last = 1'b1;
            end
        endcase
    end

    // done flags and beat counter
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done <= 1'b1;
            bus_write_done <= 1'b1;
            region <= REG_NONE;
            beat <= 1'b0;
        end else if (start_rd || start_wr) begin
            bus_read_done <= !start_rd;
            bus_write_done <= !start_wr;
            region <= req_region;
            beat <= 1'b0;
        end else if (!idle) begin
            if (resp.last) begin
                bus_read_done <= 1'b1;
                bus_write_done <= 1'b1;
                beat <= 1'b0;
            end else begin
                beat <= beat + 1'b1;
            end
        end
    end

    // beat 0 loads the whole word, beat 1 adds the upper half of ld
    always_ff @(posedge CLOCK_50) begin
        if (!bus_read_done) begin
            if (!beat) begin
                bus_read_data <= resp.read_data;
            end else begin
                bus_read_data <= bus_read_data | resp.read_data;
            end
        end
    end

endmodule

// File: logic/word_ram.sv
`timescale 1ns/1ps

module word_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic                        CLOCK_50,
    input  soc_bus_pkg::slave_access_t  ram_access,
    output soc_bus_pkg::slave_resp_t    ram_resp
);
    import soc_bus_pkg::*;

    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [WORD_W-1:0] mem [RAM_WORDS];

    logic [IDX_W-1:0]  idx;
    logic [1:0]        lane;
    logic [WORD_W-1:0] word;
    logic [WORD_W-1:0] shifted;
    logic [3:0]        byte_en;
    logic [WORD_W-1:0] lane_data;
    logic [XLEN-1:0]   load_data;
    logic              is_double;

    // byte address over four, second beat of ld/sd hits the next word
    assign lane = ram_access.address[1:0];
    assign idx = ram_access.address[IDX_W+1:2] + IDX_W'(ram_access.beat);
    assign word = mem[idx];
    // addressed byte or half moved down to bit 0
    assign shifted = word >> {lane, 3'b000};
    assign is_double = (ram_access.ls_type == LS_D);

    // store lanes
    // data is replicated across lanes, byte_en picks the ones to keep
    always_comb begin
        unique case (ram_access.ls_type)
            LS_B: begin
                byte_en = 4'b0001 << lane;
                lane_data = {4{ram_access.write_data[7:0]}};
            end
            LS_H: begin
                // aligned halves only, lane 0 or 2
                byte_en = 4'b0011 << lane;
                lane_data = {2{ram_access.write_data[15:0]}};
            end
            LS_D: begin
                byte_en = 4'b1111;
                if (ram_access.beat) begin
                    lane_data = ram_access.write_data[XLEN-1:WORD_W];
                end else begin
                    lane_data = ram_access.write_data[WORD_W-1:0];
                end
            end
            default: begin
                byte_en = 4'b1111;
                lane_data = ram_access.write_data[WORD_W-1:0];
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (ram_access.write_strobe) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[idx][8*b +: 8] <= lane_data[8*b +: 8];
                end
            end
        end
    end

    // load extension
    always_comb begin
        unique case (ram_access.ls_type)
            LS_B:  load_data = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            LS_H:  load_data = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            LS_W:  load_data = {{(XLEN-WORD_W){word[WORD_W-1]}}, word};
            LS_BU: load_data = {{(XLEN-8){1'b0}}, shifted[7:0]};
            LS_HU: load_data = {{(XLEN-16){1'b0}}, shifted[15:0]};
            LS_WU: load_data = {{(XLEN-WORD_W){1'b0}}, word};
            LS_D: begin
                // low word first, high word placed on the second beat
                if (ram_access.beat) begin
                    load_data = {word, {(XLEN-WORD_W){1'b0}}};
                end else begin
                    load_data = {{(XLEN-WORD_W){1'b0}}, word};
                end
            end
            default: load_data = '0;
        endcase
    end

    // zero when not read so the responder can OR beats together
    assign ram_resp.read_data = ram_access.read_strobe ? load_data : '0;
    // two beats for ld and sd, one for everything else
    assign ram_resp.last = !is_double || ram_access.beat;

endmodule

// File: logic/plic_regs.sv
`timescale 1ns/1ps

module plic_regs #(
    parameter int NUM_SOURCES = 4
) (
    input  logic                        CLOCK_50,
    input  logic                        KEY0,
    input  soc_bus_pkg::slave_access_t  plic_access,
    input  logic [NUM_SOURCES-1:0]      irq_sources,
    output soc_bus_pkg::slave_resp_t    plic_resp,
    output logic                        meip,
    output logic                        seip
);
    import soc_bus_pkg::*;

    localparam int ID_W = $clog2(NUM_SOURCES);

    // register file
    logic [PRIO_W-1:0]      prio [NUM_SOURCES];
    logic [NUM_SOURCES-1:0] pending;
    logic [NUM_SOURCES-1:0] enable [NUM_CTX];
    logic [PRIO_W-1:0]      threshold [NUM_CTX];

    logic [XLEN-1:0]        ofs;
    logic                   sel_prio;
    logic                   sel_pending;
    logic [NUM_CTX-1:0]     sel_enable;
    logic [NUM_CTX-1:0]     sel_thresh;
    logic [NUM_CTX-1:0]     sel_claim;
    logic [ID_W-1:0]        prio_id;
    logic [ID_W-1:0]        claim_id [NUM_CTX];
    logic [XLEN-1:0]        rdata;

    // offset decode, address is already relative to the plic base
    assign ofs = plic_access.address;
    assign sel_prio = (ofs < PRIO_STRIDE * NUM_SOURCES) && (ofs % PRIO_STRIDE == 0);
    assign prio_id = ID_W'(ofs / PRIO_STRIDE);
    assign sel_pending = (ofs == PENDING_OFS);

    always_comb begin
        for (int c = 0; c < NUM_CTX; c++) begin
            sel_enable[c] = (ofs == ENABLE_OFS + XLEN'(c) * ENABLE_STRIDE);
            sel_thresh[c] = (ofs == THRESH_OFS + XLEN'(c) * CTX_STRIDE);
            sel_claim[c] = (ofs == CLAIM_OFS + XLEN'(c) * CTX_STRIDE);
        end
    end

    // claim arbitration per context
    // strict compare, so on equal priority the lower id stays
    always_comb begin
        logic [PRIO_W-1:0] best_prio;
        for (int c = 0; c < NUM_CTX; c++) begin
            best_prio = threshold[c];
            claim_id[c] = '0;
            // id 0 is reserved for no interrupt
            for (int s = 1; s < NUM_SOURCES; s++) begin
                if (pending[s] && enable[c][s] && prio[s] > best_prio) begin
                    best_prio = prio[s];
                    claim_id[c] = ID_W'(s);
                end
            end
        end
    end

    // external interrupt lines straight from arbitration
    assign meip = (claim_id[0] != '0);
    assign seip = (claim_id[1] != '0);

    // read mux, unknown offsets read as zero
    always_comb begin
        rdata = '0;
        if (sel_prio) begin
            rdata = XLEN'(prio[prio_id]);
        end
        if (sel_pending) begin
            rdata = XLEN'(pending);
        end
        for (int c = 0; c < NUM_CTX; c++) begin
            if (sel_enable[c]) begin
                rdata = XLEN'(enable[c]);
            end
            if (sel_thresh[c]) begin
                rdata = XLEN'(threshold[c]);
            end
            if (sel_claim[c]) begin
                rdata = XLEN'(claim_id[c]);
            end
        end
    end

    assign plic_resp.read_data = plic_access.read_strobe ? rdata : '0;
    // every register access is a single beat
    assign plic_resp.last = 1'b1;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            for (int s = 0; s < NUM_SOURCES; s++) begin
                prio[s] <= '0;
            end
            pending <= '0;
            for (int c = 0; c < NUM_CTX; c++) begin
                enable[c] <= '0;
                threshold[c] <= '0;
            end
        end else begin
            // sticky capture, source 0 never pends
            pending <= pending | (irq_sources & ~NUM_SOURCES'(1));

            // pending and claim ignore writes
            if (plic_access.write_strobe) begin
                if (sel_prio) begin
                    prio[prio_id] <= plic_access.write_data[PRIO_W-1:0];
                end
                for (int c = 0; c < NUM_CTX; c++) begin
                    if (sel_enable[c]) begin
                        enable[c] <= plic_access.write_data[NUM_SOURCES-1:0];
                    end
                    if (sel_thresh[c]) begin
                        threshold[c] <= plic_access.write_data[PRIO_W-1:0];
                    end
                end
            end

            // claim by read clears the winner, wins over a new capture
            if (plic_access.read_strobe) begin
                for (int c = 0; c < NUM_CTX; c++) begin
                    if (sel_claim[c] && claim_id[c] != '0) begin
                        pending[claim_id[c]] <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

// File: logic/soc_periph_top.sv
`timescale 1ns/1ps

module soc_periph_top #(
    parameter int RAM_WORDS = 256,
    parameter int NUM_SOURCES = 4
) (
    input  logic                          CLOCK_50,
    input  logic                          KEY0,
    input  soc_bus_pkg::bus_req_t         bus_req,
    input  logic [NUM_SOURCES-1:0]        irq_sources,
    output logic [soc_bus_pkg::XLEN-1:0]  bus_read_data,
    output logic                          bus_read_done,
    output logic                          bus_write_done,
    output logic                          meip,
    output logic                          seip
);
    import soc_bus_pkg::*;

    // responder to slaves
    slave_access_t ram_access;
    slave_access_t plic_access;
    // slaves back to responder
    slave_resp_t   ram_resp;
    slave_resp_t   plic_resp;

    // front end, decode and beat sequencing
    bus_responder #(
        .RAM_WORDS (RAM_WORDS)
    ) u_bus_responder (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .bus_req        (bus_req),
        .ram_access     (ram_access),
        .plic_access    (plic_access),
        .ram_resp       (ram_resp),
        .plic_resp      (plic_resp),
        .bus_read_data  (bus_read_data),
        .bus_read_done  (bus_read_done),
        .bus_write_done (bus_write_done)
    );

    word_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_word_ram (
        .CLOCK_50   (CLOCK_50),
        .ram_access (ram_access),
        .ram_resp   (ram_resp)
    );

    // interrupt controller, machine and supervisor contexts
    plic_regs #(
        .NUM_SOURCES (NUM_SOURCES)
    ) u_plic_regs (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .plic_access (plic_access),
        .irq_sources (irq_sources),
        .plic_resp   (plic_resp),
        .meip        (meip),
        .seip        (seip)
    );

endmodule

// File: test/tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
    parameter int RAM_WORDS = 256,
    parameter int NUM_SOURCES = 4
) (
    input  logic                          CLOCK_50,
    input  logic                          KEY0,
    input  soc_bus_pkg::bus_req_t         bus_req,
    input  logic [NUM_SOURCES-1:0]        irq_sources,
    input  logic [soc_bus_pkg::XLEN-1:0]  bus_read_data,
    input  logic                          bus_read_done,
    input  logic                          bus_write_done,
    input  logic                          meip,
    input  logic                          seip,
    output int                            errors,
    output int                            checks
);
    import soc_bus_pkg::*;

    // ram image and interrupt controller model
    logic [WORD_W-1:0]      ram_img [RAM_WORDS];
    logic [PRIO_W-1:0]      m_prio [NUM_SOURCES];
    logic [NUM_SOURCES-1:0] m_pending;
    logic [NUM_SOURCES-1:0] m_enable [NUM_CTX];
    logic [PRIO_W-1:0]      m_thresh [NUM_CTX];

    // request in flight
    logic                   busy;
    bus_req_t               req;
    region_t                req_region;
    int                     edges;
    logic [XLEN-1:0]        exp_data;

    initial begin
        errors = 0;
        checks = 0;
    end

    task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("Error %s expected %0h got %0h", name, exp, got);
        end
    endtask

    function automatic region_t decode(input logic [XLEN-1:0] a);
        if (a >= RAM_BASE_ADDR && a < RAM_BASE_ADDR + XLEN'(RAM_WORDS * 4)) begin
            return REG_RAM;
        end
        if (a >= PLIC_BASE_ADDR && a < PLIC_BASE_ADDR + PLIC_SIZE_BYTES) begin
            return REG_PLIC;
        end
        return REG_NONE;
    endfunction

    // walk priority levels from the top down to just above the threshold
    // lowest id wins within a level and 0 means none
    function automatic int claim_of(input int ctx);
        for (int p = (1 << PRIO_W) - 1; p > int'(m_thresh[ctx]); p--) begin
            for (int s = 1; s < NUM_SOURCES; s++) begin
                if (m_pending[s] && m_enable[ctx][s] && int'(m_prio[s]) == p) begin
                    return s;
                end
            end
        end
        return 0;
    endfunction

    function automatic logic [XLEN-1:0] ram_load(input logic [XLEN-1:0] ofs, input ls_type_t ls);
        int idx;
        logic [WORD_W-1:0] w;
        logic [7:0] b;
        logic [15:0] h;
        idx = int'(ofs >> 2);
        w = ram_img[idx];
        b = w[8 * int'(ofs[1:0]) +: 8];
        h = ofs[1] ? w[31:16] : w[15:0];
        case (ls)
            LS_B:    return {{56{b[7]}}, b};
            LS_H:    return {{48{h[15]}}, h};
            LS_W:    return {{32{w[31]}}, w};
            LS_BU:   return {56'h0, b};
            LS_HU:   return {48'h0, h};
            LS_WU:   return {32'h0, w};
            // low word at the address and high word in the next one
            LS_D:    return {ram_img[idx + 1], w};
            default: return '0;
        endcase
    endfunction

    task automatic ram_store(input logic [XLEN-1:0] ofs, input ls_type_t ls,
                             input logic [XLEN-1:0] d);
        int idx;
        int lane;
        idx = int'(ofs >> 2);
        lane = int'(ofs[1:0]);
        case (ls)
            LS_B: ram_img[idx][8*lane +: 8] = d[7:0];
            LS_H: ram_img[idx][8*lane +: 16] = d[15:0];
            LS_D: begin
                ram_img[idx] = d[31:0];
                ram_img[idx + 1] = d[63:32];
            end
            default: ram_img[idx] = d[31:0];
        endcase
    endtask

    // register access on the strobe edge
    // claim clear handed back as a mask
    task automatic plic_model(input logic [XLEN-1:0] ofs, input logic wr,
                              input logic [XLEN-1:0] d, output logic [XLEN-1:0] rd,
                              output logic [NUM_SOURCES-1:0] clr);
        int id;
        rd = '0;
        clr = '0;
        for (int s = 0; s < NUM_SOURCES; s++) begin
            if (ofs == XLEN'(4 * s)) begin
                rd = XLEN'(m_prio[s]);
                if (wr) begin
                    m_prio[s] = d[PRIO_W-1:0];
                end
            end
        end
        if (ofs == PENDING_OFS) begin
            rd = XLEN'(m_pending);
        end
        for (int c = 0; c < NUM_CTX; c++) begin
            if (ofs == ENABLE_OFS + XLEN'(c) * ENABLE_STRIDE) begin
                rd = XLEN'(m_enable[c]);
                if (wr) begin
                    m_enable[c] = d[NUM_SOURCES-1:0];
                end
            end
            if (ofs == THRESH_OFS + XLEN'(c) * CTX_STRIDE) begin
                rd = XLEN'(m_thresh[c]);
                if (wr) begin
                    m_thresh[c] = d[PRIO_W-1:0];
                end
            end
            if (ofs == CLAIM_OFS + XLEN'(c) * CTX_STRIDE) begin
                id = claim_of(c);
                rd = XLEN'(id);
                // only a read claims
                if (!wr && id != 0) begin
                    clr[id] = 1'b1;
                end
            end
        end
    endtask

    task automatic finish_access();
        int want;
        // ld and sd take one more beat
        want = (req_region == REG_RAM && req.ls_type == LS_D) ? 3 : 2;
        checks++;
        if (edges != want) begin
            errors++;
            $display("done for address %h came %0d edges after the request instead of %0d",
                     req.address, edges, want);
        end
        if (req_region == REG_RAM && req.write_enable) begin
            ram_store(req.address - RAM_BASE_ADDR, req.ls_type, req.write_data);
        end
        if (req.read_enable) begin
            if (req_region == REG_RAM) begin
                exp_data = ram_load(req.address - RAM_BASE_ADDR, req.ls_type);
            end else if (req_region == REG_NONE) begin
                exp_data = '0;
            end
            check_value("bus_read_data", exp_data, bus_read_data);
        end
        busy = 1'b0;
    endtask

    always @(posedge CLOCK_50) begin
        logic [NUM_SOURCES-1:0] clr;
        logic done_now;
        clr = '0;
        if (!KEY0) begin
            busy = 1'b0;
            m_pending = '0;
            for (int s = 0; s < NUM_SOURCES; s++) begin
                m_prio[s] = '0;
            end
            for (int c = 0; c < NUM_CTX; c++) begin
                m_enable[c] = '0;
                m_thresh[c] = '0;
            end
        end else begin
            // interrupt lines against the state before this edge
            check_value("meip", XLEN'(claim_of(0) != 0), XLEN'(meip));
            check_value("seip", XLEN'(claim_of(1) != 0), XLEN'(seip));
            if (busy) begin
                edges++;
                if (edges == 1 && req_region == REG_PLIC) begin
                    plic_model(req.address - PLIC_BASE_ADDR, req.write_enable,
                               req.write_data, exp_data, clr);
                end
                done_now = req.write_enable ? bus_write_done : bus_read_done;
                if (done_now) begin
                    finish_access();
                end
            end else begin
                // idle bus shows both flags high
                check_value("bus_read_done", 1, XLEN'(bus_read_done));
                check_value("bus_write_done", 1, XLEN'(bus_write_done));
                if (bus_req.read_enable || bus_req.write_enable) begin
                    req = bus_req;
                    req_region = decode(bus_req.address);
                    edges = 0;
                    busy = 1'b1;
                end
            end
            // sticky capture where a claim on the same edge wins
            m_pending = (m_pending | (irq_sources & ~NUM_SOURCES'(1))) & ~clr;
        end
    end

endmodule

// File: test/tb_top.sv
`timescale 1ns/1ps

module tb_top;
    import soc_bus_pkg::*;

    localparam int RAM_WORDS = 256;
    localparam int NUM_SOURCES = 4;
    localparam int TIMEOUT = 50;
    // nothing decodes here
    localparam logic [XLEN-1:0] UNMAPPED_ADDR = 64'h0000_0000_4000_0000;

    logic                   CLOCK_50;
    logic                   KEY0;
    bus_req_t               bus_req;
    logic [NUM_SOURCES-1:0] irq_sources;
    logic [XLEN-1:0]        bus_read_data;
    logic                   bus_read_done;
    logic                   bus_write_done;
    logic                   meip;
    logic                   seip;
    int                     errors;
    int                     checks;
    int                     timeouts;
    int                     errors_before;
    int                     seed_val;

    soc_periph_top #(
        .RAM_WORDS   (RAM_WORDS),
        .NUM_SOURCES (NUM_SOURCES)
    ) DUT (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .bus_req        (bus_req),
        .irq_sources    (irq_sources),
        .bus_read_data  (bus_read_data),
        .bus_read_done  (bus_read_done),
        .bus_write_done (bus_write_done),
        .meip           (meip),
        .seip           (seip)
    );

    tb_checker #(
        .RAM_WORDS   (RAM_WORDS),
        .NUM_SOURCES (NUM_SOURCES)
    ) u_checker (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .bus_req        (bus_req),
        .irq_sources    (irq_sources),
        .bus_read_data  (bus_read_data),
        .bus_read_done  (bus_read_done),
        .bus_write_done (bus_write_done),
        .meip           (meip),
        .seip           (seip),
        .errors         (errors),
        .checks         (checks)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #5 CLOCK_50 = ~CLOCK_50;
    end

    // one pulse, then wait for the matching done
    task automatic bus_access(input logic wr, input logic [XLEN-1:0] addr,
                              input ls_type_t ls, input logic [XLEN-1:0] data);
        int n;
        // bus stuck already, skip instead of stacking timeouts
        if (timeouts != 0) return;
        bus_req.address <= addr;
        bus_req.write_data <= data;
        bus_req.ls_type <= ls;
        bus_req.read_enable <= !wr;
        bus_req.write_enable <= wr;
        @(posedge CLOCK_50);
        bus_req.read_enable <= 1'b0;
        bus_req.write_enable <= 1'b0;
        n = 0;
        @(posedge CLOCK_50);
        while (!(wr ? bus_write_done : bus_read_done) && n < TIMEOUT) begin
            @(posedge CLOCK_50);
            n++;
        end
        if (n >= TIMEOUT) begin
            timeouts++;
            $display("timeout, no done within %0d cycles for address %h", TIMEOUT, addr);
        end
    endtask

    task automatic plic_write(input logic [XLEN-1:0] ofs, input logic [XLEN-1:0] data);
        bus_access(1'b1, PLIC_BASE_ADDR + ofs, LS_W, data);
    endtask

    task automatic plic_read(input logic [XLEN-1:0] ofs);
        bus_access(1'b0, PLIC_BASE_ADDR + ofs, LS_W, '0);
    endtask

    // one cycle of irq lines
    task automatic pulse_irq(input logic [NUM_SOURCES-1:0] bits);
        irq_sources <= bits;
        @(posedge CLOCK_50);
        irq_sources <= '0;
        @(posedge CLOCK_50);
    endtask

    // aligned to the access size
    function automatic logic [XLEN-1:0] random_ram_addr(input ls_type_t ls);
        logic [XLEN-1:0] ofs;
        ofs = XLEN'($urandom_range(RAM_WORDS * 4 - 1, 0));
        case (ls)
            LS_H, LS_HU: ofs[0] = 1'b0;
            LS_W, LS_WU: ofs[1:0] = 2'b00;
            LS_D:        ofs[2:0] = 3'b000;
            default: ;
        endcase
        return RAM_BASE_ADDR + ofs;
    endfunction

    task automatic random_plic_config(input int min_prio);
        for (int s = 1; s < NUM_SOURCES; s++) begin
            plic_write(XLEN'(4 * s), XLEN'($urandom_range(7, min_prio)));
        end
        for (int c = 0; c < NUM_CTX; c++) begin
            plic_write(ENABLE_OFS + XLEN'(c) * ENABLE_STRIDE, XLEN'($urandom_range(15, 0)));
            plic_write(THRESH_OFS + XLEN'(c) * CTX_STRIDE, XLEN'($urandom_range(7 - min_prio, 0)));
        end
    endtask

    // sample the counts away from the clock edge
    task automatic report_test(input int num, input string name);
        @(negedge CLOCK_50);
        $display("test %0d %s: %0d errors", num, name, errors - errors_before);
        errors_before = errors;
        @(posedge CLOCK_50);
    endtask

    initial begin
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
        ls_type_t        ls;
        logic            wr;
        seed_val = $urandom(32'he6cc_99b2);
        KEY0 = 1'b0;
        bus_req = '0;
        irq_sources = '0;
        timeouts = 0;
        errors_before = 0;
        repeat (8) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        repeat (3) @(posedge CLOCK_50);

        // idle flags checked every cycle, then fill the ram
        for (int i = 0; i < RAM_WORDS; i++) begin
            bus_access(1'b1, RAM_BASE_ADDR + XLEN'(4 * i), LS_W, XLEN'($urandom()));
        end
        report_test(1, "reset state and ram fill");

        for (int i = 0; i < 200; i++) begin
            ls = ls_type_t'($urandom_range(6, 0));
            wr = ($urandom_range(1, 0) == 1) && (ls <= LS_D);
            data = {$urandom(), $urandom()};
            bus_access(wr, random_ram_addr(ls), ls, data);
        end
        report_test(2, "random ram loads and stores");

        // every access kind, edge counts compared in the checker
        for (int i = 0; i < 10; i++) begin
            addr = random_ram_addr(LS_D);
            data = {$urandom(), $urandom()};
            bus_access(1'b1, addr, LS_D, data);
            bus_access(1'b0, addr, LS_D, '0);
            bus_access(1'b1, random_ram_addr(LS_B), LS_B, data);
            bus_access(1'b0, random_ram_addr(LS_HU), LS_HU, '0);
            plic_read(PENDING_OFS);
            bus_access(1'b1, UNMAPPED_ADDR, LS_W, data);
        end
        report_test(3, "done timing and ld/sd round trip");

        for (int r = 0; r < 8; r++) begin
            random_plic_config(0);
            pulse_irq(NUM_SOURCES'(1) << $urandom_range(NUM_SOURCES - 1, 0));
            plic_read(PENDING_OFS);
        end
        report_test(4, "interrupt config, pending and meip/seip");

        random_plic_config(1);
        for (int r = 0; r < 12; r++) begin
            pulse_irq(NUM_SOURCES'($urandom_range(15, 0)));
            for (int c = 0; c < NUM_CTX; c++) begin
                plic_read(CLAIM_OFS + XLEN'(c) * CTX_STRIDE);
            end
            plic_read(PENDING_OFS);
        end
        // pending and claim ignore writes
        plic_write(PENDING_OFS, '1);
        plic_write(CLAIM_OFS, '0);
        plic_read(PENDING_OFS);
        bus_access(1'b0, UNMAPPED_ADDR, LS_D, '0);
        report_test(5, "claim per context and unmapped read");

        @(negedge CLOCK_50);
        $display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+include
logic/soc_bus_pkg.sv
logic/bus_responder.sv
logic/word_ram.sv
logic/plic_regs.sv
logic/soc_periph_top.sv
test/tb_checker.sv
test/tb_top.sv
